/* all.f */
+incdir+source
source/periph_pkg.sv
source/wb_periph_bridge.sv
source/periph_decoder.sv
source/gpio_block.sv
source/timer_block.sv
source/periph_subsystem.sv
tests/tb_periph_subsystem.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_periph_subsystem -f all.f

sim_output=$(./obj_dir/Vtb_periph_subsystem 2>&1) || true
echo "$sim_output"
grep -q "ALL TESTS PASSED" <<< "$sim_output"

/* tests/tb_periph_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "periph_config.svh"

module tb_periph_subsystem;

	logic wb_clk_i = 1'b0;
	logic wb_rst_i;
	logic wb_cyc_i;
	logic wb_stb_i;
	logic wb_we_i;
	logic [3:0] wb_sel_i;
	logic [23:0] wb_adr_i;
	logic [31:0] wb_dat_i;
	logic [31:0] gpio_in_i;
	wire [31:0] wb_dat_o;
	wire wb_ack_o;
	wire wb_stall_o;
	wire [31:0] gpio_out_o;
	wire [31:0] gpio_oe_o;
	wire timer_irq_o;

	// Scoreboard state
	logic pending;
	logic [3:0] age;
	logic [3:0] exp_lat;
	logic cap_we;
	logic [23:0] cap_adr;
	logic [3:0] cap_sel;
	logic [31:0] cap_dat;
	logic cap_check;
	logic [31:0] cap_exp;
	logic [31:0] exp_out;
	logic [31:0] exp_oe;
	logic exp_en;
	logic [31:0] exp_cmp;
	logic [31:0] rng_state;

	periph_subsystem periph_subsystem_inst (
		.wb_clk_i(wb_clk_i), .wb_rst_i(wb_rst_i),
		.wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i),
		.wb_sel_i(wb_sel_i), .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i),
		.wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o), .wb_stall_o(wb_stall_o),
		.gpio_in_i(gpio_in_i), .gpio_out_o(gpio_out_o), .gpio_oe_o(gpio_oe_o),
		.timer_irq_o(timer_irq_o)
	);

	always #20 wb_clk_i = ~wb_clk_i;

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("SOME TESTS FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		$display("FAIL time %0t %s expected %h actual %h", $time, name, expected, actual);
		abort_run("value mismatch");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected) else report_mismatch(name, expected, actual);
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_random();
		rng_state = xorshift(rng_state);
		return rng_state;
	endfunction

	function automatic logic [31:0] lane_merge(input logic [31:0] old_w,
			input logic [31:0] new_w, input logic [3:0] sel);
		logic [31:0] mask;
		mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
		return (old_w & ~mask) | (new_w & mask);
	endfunction

	function automatic logic [23:0] reg_addr(input logic [3:0] dev, input logic [3:0] idx);
		return {4'h0, dev, 10'h0, idx, 2'b00};
	endfunction

	// Top bit says whether the read value is predictable
	function automatic logic [32:0] expected_read(input logic [23:0] adr);
		logic [3:0] dev;
		logic [3:0] idx;
		dev = adr[19:16];
		idx = adr[5:2];
		if (dev == `PERIPH_DEV_ID && idx == 4'd0)
			return {1'b1, `PERIPH_SUBSYSTEM_ID};
		if (dev == `PERIPH_DEV_GPIO && idx <= 4'd2)
			return (idx == 4'd0) ? {1'b1, exp_out} : (idx == 4'd1) ? {1'b1, exp_oe} : 33'h0;
		if (dev == `PERIPH_DEV_TIMER && idx <= 4'd3)
			return (idx == 4'd0) ? {1'b1, 31'h0, exp_en} : (idx == 4'd1) ? {1'b1, exp_cmp} : 33'h0;
		return {1'b1, `PERIPH_UNMAPPED_DATA};
	endfunction

	// ------------------------------------------------------------------
	// Reference model, updated on acceptance and on ack
	// ------------------------------------------------------------------
	always @(posedge wb_clk_i) begin
		if (wb_rst_i) begin
			pending <= 1'b0;
			age <= '0;
			exp_lat <= 4'd2;
			cap_check <= 1'b0;
			exp_out <= '0;
			exp_oe <= '0;
			exp_en <= 1'b0;
			exp_cmp <= '0;
		end else begin
			age <= age + 4'd1;
			if (wb_ack_o) begin
				pending <= 1'b0;
				if (cap_we && cap_adr[19:16] == `PERIPH_DEV_GPIO && cap_adr[5:2] == 4'd0)
					exp_out <= lane_merge(exp_out, cap_dat, cap_sel);
				if (cap_we && cap_adr[19:16] == `PERIPH_DEV_GPIO && cap_adr[5:2] == 4'd1)
					exp_oe <= lane_merge(exp_oe, cap_dat, cap_sel);
				if (cap_we && cap_adr[19:16] == `PERIPH_DEV_TIMER && cap_adr[5:2] == 4'd0
						&& cap_sel[0])
					exp_en <= cap_dat[0];
				if (cap_we && cap_adr[19:16] == `PERIPH_DEV_TIMER && cap_adr[5:2] == 4'd1)
					exp_cmp <= lane_merge(exp_cmp, cap_dat, cap_sel);
			end
			if (wb_cyc_i && wb_stb_i && !wb_stall_o) begin
				pending <= 1'b1;
				age <= 4'd1;
				exp_lat <= (wb_adr_i[19:16] == `PERIPH_DEV_TIMER) ? 4'd3 : 4'd2;
				cap_we <= wb_we_i;
				cap_adr <= wb_adr_i;
				cap_sel <= wb_sel_i;
				cap_dat <= wb_dat_i;
				{cap_check, cap_exp} <= expected_read(wb_adr_i);
				if (wb_we_i)
					cap_check <= 1'b0;
			end
		end
	end

	assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
		wb_ack_o |-> (pending && age == exp_lat))
		else abort_run("ack seen without an outstanding access or at the wrong cycle");
	assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
		(pending && age == exp_lat) |-> wb_ack_o)
		else abort_run("access was not acknowledged on time");
	assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
		wb_stall_o == (pending && age < exp_lat))
		else report_mismatch("wb_stall_o", {31'h0, $sampled(pending && age < exp_lat)},
			{31'h0, $sampled(wb_stall_o)});
	assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
		(wb_ack_o && cap_check) |-> wb_dat_o == cap_exp)
		else report_mismatch("wb_dat_o", $sampled(cap_exp), $sampled(wb_dat_o));
	assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
		!pending |-> gpio_out_o == exp_out)
		else report_mismatch("gpio_out_o", $sampled(exp_out), $sampled(gpio_out_o));
	assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
		!pending |-> gpio_oe_o == exp_oe)
		else report_mismatch("gpio_oe_o", $sampled(exp_oe), $sampled(gpio_oe_o));

	// ------------------------------------------------------------------
	// Wishbone driver, called and returning just after a rising edge
	// ------------------------------------------------------------------
	task automatic wb_access(input logic we, input logic [23:0] adr, input logic [3:0] sel,
			input logic [31:0] dat, output logic [31:0] rdata);
		int waited;
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		wb_we_i = we;
		wb_adr_i = adr;
		wb_sel_i = sel;
		wb_dat_i = dat;
		waited = 0;
		@(negedge wb_clk_i);
		while (wb_stall_o) begin
			waited++;
			if (waited > 20)
				abort_run("strobe was not accepted before the timeout");
			@(negedge wb_clk_i);
		end
		@(posedge wb_clk_i);
		#2;
		wb_stb_i = 1'b0;
		wb_we_i = 1'b0;
		waited = 0;
		@(negedge wb_clk_i);
		while (!wb_ack_o) begin
			waited++;
			if (waited > 20)
				abort_run("no ack before the timeout");
			@(negedge wb_clk_i);
		end
		rdata = wb_dat_o;
		@(posedge wb_clk_i);
		#2;
		wb_cyc_i = 1'b0;
	endtask

	task automatic wb_write(input logic [23:0] adr, input logic [3:0] sel, input logic [31:0] dat);
		logic [31:0] unused_data;
		wb_access(1'b1, adr, sel, dat, unused_data);
	endtask

	task automatic wb_read(input logic [23:0] adr, output logic [31:0] rdata);
		wb_access(1'b0, adr, 4'hf, 32'h0, rdata);
	endtask

	initial begin
		logic [31:0] rdata;
		logic [31:0] pins;
		logic [31:0] count_a;
		logic [3:0] rand_sel;
		logic [31:0] rand_data;
		int waited;
		rng_state = 32'h352d1527;
		wb_rst_i = 1'b1;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i = 1'b0;
		wb_sel_i = 4'h0;
		wb_adr_i = '0;
		wb_dat_i = '0;
		gpio_in_i = '0;
		repeat (2) @(posedge wb_clk_i);
		#2;
		wb_rst_i = 1'b0;

		@(negedge wb_clk_i);
		check_value("wb_ack_o", 32'h0, {31'h0, wb_ack_o});
		check_value("wb_stall_o", 32'h0, {31'h0, wb_stall_o});
		check_value("gpio_out_o", 32'h0, gpio_out_o);
		check_value("gpio_oe_o", 32'h0, gpio_oe_o);
		check_value("timer_irq_o", 32'h0, {31'h0, timer_irq_o});
		@(posedge wb_clk_i);
		#2;

		// ID register and unmapped space
		wb_read(reg_addr(`PERIPH_DEV_ID, 4'd0), rdata);
		wb_read(reg_addr(`PERIPH_DEV_ID, 4'd1), rdata);
		wb_read(reg_addr(4'h7, 4'd3), rdata);

		for (int i = 0; i < 16; i++) begin
			rand_sel = 4'(next_random());
			rand_data = next_random();
			wb_write(reg_addr(`PERIPH_DEV_GPIO, 4'(i % 2)), rand_sel, rand_data);
			wb_read(reg_addr(`PERIPH_DEV_GPIO, 4'(i % 2)), rdata);
		end
		wb_write(reg_addr(`PERIPH_DEV_ID, 4'd1), 4'hf, next_random());
		wb_write(reg_addr(4'h7, 4'd0), 4'hf, next_random());
		wb_read(reg_addr(`PERIPH_DEV_GPIO, 4'd0), rdata);
		wb_read(reg_addr(`PERIPH_DEV_GPIO, 4'd1), rdata);
		wb_read(reg_addr(`PERIPH_DEV_GPIO, 4'd5), rdata);

		// Pins settle through the synchronizer
		for (int i = 0; i < 4; i++) begin
			pins = next_random();
			gpio_in_i = pins;
			repeat (3) @(posedge wb_clk_i);
			#2;
			wb_read(reg_addr(`PERIPH_DEV_GPIO, 4'd2), rdata);
			check_value("gpio input register", pins, rdata);
		end

		// ------------------------------------------------------------------
		// Timer
		// ------------------------------------------------------------------
		wb_write(reg_addr(`PERIPH_DEV_TIMER, 4'd1), 4'hf, 32'd5);
		wb_read(reg_addr(`PERIPH_DEV_TIMER, 4'd1), rdata);
		wb_write(reg_addr(`PERIPH_DEV_TIMER, 4'd0), 4'h1, 32'd1);
		wb_read(reg_addr(`PERIPH_DEV_TIMER, 4'd0), rdata);
		waited = 0;
		@(negedge wb_clk_i);
		while (!timer_irq_o) begin
			waited++;
			if (waited > 50)
				abort_run("timer interrupt did not rise before the timeout");
			@(negedge wb_clk_i);
		end
		@(posedge wb_clk_i);
		#2;
		wb_read(reg_addr(`PERIPH_DEV_TIMER, 4'd3), rdata);
		check_value("timer status", 32'h1, rdata);
		for (int i = 0; i < 8; i++) begin
			wb_read(reg_addr(`PERIPH_DEV_TIMER, 4'd2), rdata);
			assert (rdata <= 32'd5) else abort_run("timer count read exceeds compare");
		end

		// Stop first so no new match races the clear
		wb_write(reg_addr(`PERIPH_DEV_TIMER, 4'd0), 4'h1, 32'd0);
		wb_read(reg_addr(`PERIPH_DEV_TIMER, 4'd2), count_a);
		wb_write(reg_addr(`PERIPH_DEV_TIMER, 4'd3), 4'h1, 32'd1);
		check_value("timer_irq_o", 32'h0, {31'h0, timer_irq_o});
		wb_read(reg_addr(`PERIPH_DEV_TIMER, 4'd2), rdata);
		check_value("timer count", count_a, rdata);

		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* source/periph_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "periph_config.svh"

module periph_subsystem (
	input  wire                           wb_clk_i,
	input  wire                           wb_rst_i,
	input  wire                           wb_cyc_i,
	input  wire                           wb_stb_i,
	input  wire                           wb_we_i,
	input  wire [3:0]                     wb_sel_i,
	input  wire [`PERIPH_ADDR_WIDTH-1:0]  wb_adr_i,
	input  wire [`PERIPH_DATA_WIDTH-1:0]  wb_dat_i,
	output wire [`PERIPH_DATA_WIDTH-1:0]  wb_dat_o,
	output wire                           wb_ack_o,
	output wire                           wb_stall_o,
	input  wire [`GPIO_WIDTH-1:0]         gpio_in_i,
	output wire [`GPIO_WIDTH-1:0]         gpio_out_o,
	output wire [`GPIO_WIDTH-1:0]         gpio_oe_o,
	output wire                           timer_irq_o
);
	import periph_pkg::*;

	periph_req_t bus_req;
	periph_req_t gpio_req;
	periph_req_t timer_req;
	periph_rsp_t bus_rsp;
	periph_rsp_t gpio_rsp;
	periph_rsp_t timer_rsp;

	wb_periph_bridge wb_periph_bridge_inst (
		.wb_clk_i(wb_clk_i), .wb_rst_i(wb_rst_i),
		.wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i),
		.wb_sel_i(wb_sel_i), .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i),
		.wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o), .wb_stall_o(wb_stall_o),
		.bus_rsp_i(bus_rsp), .bus_req_o(bus_req)
	);

	periph_decoder periph_decoder_inst (
		.wb_clk_i(wb_clk_i), .wb_rst_i(wb_rst_i),
		.bus_req_i(bus_req), .gpio_rsp_i(gpio_rsp), .timer_rsp_i(timer_rsp),
		.bus_rsp_o(bus_rsp), .gpio_req_o(gpio_req), .timer_req_o(timer_req)
	);

	gpio_block #(.GPIO_WIDTH(`GPIO_WIDTH)) gpio_block_inst (
		.wb_clk_i(wb_clk_i), .wb_rst_i(wb_rst_i),
		.req_i(gpio_req), .gpio_in_i(gpio_in_i),
		.rsp_o(gpio_rsp), .gpio_out_o(gpio_out_o), .gpio_oe_o(gpio_oe_o)
	);

	timer_block timer_block_inst (
		.wb_clk_i(wb_clk_i), .wb_rst_i(wb_rst_i),
		.req_i(timer_req), .rsp_o(timer_rsp), .timer_irq_o(timer_irq_o)
	);

endmodule

`default_nettype wire

/* source/timer_block.sv */
`timescale 1ns/1ps
`default_nettype none

`include "periph_config.svh"

module timer_block (
	input  wire                           wb_clk_i,
	input  wire                           wb_rst_i,
	input  wire periph_pkg::periph_req_t  req_i,
	output periph_pkg::periph_rsp_t       rsp_o,
	output logic                          timer_irq_o
);
	import periph_pkg::*;

	logic enable_q;
	logic match_q;
	logic wait_q;
	logic [`PERIPH_DATA_WIDTH-1:0] compare_q;
	logic [`PERIPH_DATA_WIDTH-1:0] count_q;
	logic [`PERIPH_REG_BITS-1:0] reg_index;
	logic active;
	logic wr_en;

	assign reg_index = req_i.address.fields.reg_index;
	assign active = req_i.we || req_i.oe;
	// Writes land on the completing cycle
	assign wr_en = req_i.we && wait_q;

	// Wait state, first active cycle only
	always_ff @(posedge wb_clk_i) begin
		if (wb_rst_i) begin
			wait_q <= 1'b0;
		end else begin
			wait_q <= active && !wait_q;
		end
	end

	always_ff @(posedge wb_clk_i) begin
		if (wb_rst_i) begin
			enable_q <= 1'b0;
			match_q <= 1'b0;
			compare_q <= '0;
			count_q <= '0;
		end else begin
			if (wr_en && reg_index == 4'd0 && req_i.byte_select[0]) begin
				enable_q <= req_i.data_write[0];
			end
			if (wr_en && reg_index == 4'd1) begin
				compare_q <= byte_merge(compare_q, req_i.data_write, req_i.byte_select);
			end
			if (wr_en && reg_index == 4'd3 && req_i.byte_select[0] && req_i.data_write[0]) begin
				match_q <= 1'b0;
			end
			// A new match wins over a clear
			if (enable_q) begin
				if (count_q == compare_q) begin
					count_q <= '0;
					match_q <= 1'b1;
				end else begin
					count_q <= count_q + 1'b1;
				end
			end
		end
	end

	always_comb begin
		rsp_o.busy = active && !wait_q;
		case (reg_index)
			4'd0: rsp_o.data_read = {{(`PERIPH_DATA_WIDTH-1){1'b0}}, enable_q};
			4'd1: rsp_o.data_read = compare_q;
			4'd2: rsp_o.data_read = count_q;
			4'd3: rsp_o.data_read = {{(`PERIPH_DATA_WIDTH-1){1'b0}}, match_q};
			default: rsp_o.data_read = `PERIPH_UNMAPPED_DATA;
		endcase
	end

	assign timer_irq_o = match_q;

	// One wait cycle, with the request still held after it
	assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
		rsp_o.busy |=> (active && !rsp_o.busy));

endmodule

`default_nettype wire

/* source/gpio_block.sv */
`timescale 1ns/1ps
`default_nettype none

`include "periph_config.svh"

module gpio_block #(
	parameter int GPIO_WIDTH = `GPIO_WIDTH
) (
	input  wire                           wb_clk_i,
	input  wire                           wb_rst_i,
	input  wire periph_pkg::periph_req_t  req_i,
	input  wire [GPIO_WIDTH-1:0]          gpio_in_i,
	output periph_pkg::periph_rsp_t       rsp_o,
	output logic [GPIO_WIDTH-1:0]         gpio_out_o,
	output logic [GPIO_WIDTH-1:0]         gpio_oe_o
);
	import periph_pkg::*;

	logic [GPIO_WIDTH-1:0] out_q;
	logic [GPIO_WIDTH-1:0] oe_q;
	logic [GPIO_WIDTH-1:0] in_meta_q;
	logic [GPIO_WIDTH-1:0] in_sync_q;
	logic [`PERIPH_DATA_WIDTH-1:0] out_word;
	logic [`PERIPH_DATA_WIDTH-1:0] oe_word;
	logic [`PERIPH_DATA_WIDTH-1:0] in_word;
	logic [`PERIPH_DATA_WIDTH-1:0] out_merged;
	logic [`PERIPH_DATA_WIDTH-1:0] oe_merged;
	logic [`PERIPH_REG_BITS-1:0] reg_index;

	assign reg_index = req_i.address.fields.reg_index;

	// Registers widened to a bus word
	always_comb begin
		out_word = '0;
		oe_word = '0;
		in_word = '0;
		out_word[GPIO_WIDTH-1:0] = out_q;
		oe_word[GPIO_WIDTH-1:0] = oe_q;
		in_word[GPIO_WIDTH-1:0] = in_sync_q;
	end

	assign out_merged = byte_merge(out_word, req_i.data_write, req_i.byte_select);
	assign oe_merged = byte_merge(oe_word, req_i.data_write, req_i.byte_select);

	always_ff @(posedge wb_clk_i) begin
		if (wb_rst_i) begin
			out_q <= '0;
			oe_q <= '0;
		end else if (req_i.we) begin
			if (reg_index == 4'd0) begin
				out_q <= out_merged[GPIO_WIDTH-1:0];
			end
			if (reg_index == 4'd1) begin
				oe_q <= oe_merged[GPIO_WIDTH-1:0];
			end
		end
	end

	// Two-flop input synchronizer
	always_ff @(posedge wb_clk_i) begin
		in_meta_q <= gpio_in_i;
		in_sync_q <= in_meta_q;
	end

	always_comb begin
		rsp_o.busy = 1'b0;
		case (reg_index)
			4'd0: rsp_o.data_read = out_word;
			4'd1: rsp_o.data_read = oe_word;
			4'd2: rsp_o.data_read = in_word;
			default: rsp_o.data_read = `PERIPH_UNMAPPED_DATA;
		endcase
	end

	assign gpio_out_o = out_q;
	assign gpio_oe_o = oe_q;

endmodule

`default_nettype wire

/* source/periph_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "periph_config.svh"

module periph_decoder (
	input  wire                           wb_clk_i,
	input  wire                           wb_rst_i,
	input  wire periph_pkg::periph_req_t  bus_req_i,
	input  wire periph_pkg::periph_rsp_t  gpio_rsp_i,
	input  wire periph_pkg::periph_rsp_t  timer_rsp_i,
	output periph_pkg::periph_rsp_t       bus_rsp_o,
	output periph_pkg::periph_req_t       gpio_req_o,
	output periph_pkg::periph_req_t       timer_req_o
);
	import periph_pkg::*;

	logic [`PERIPH_DEV_BITS-1:0] device;
	logic [`PERIPH_REG_BITS-1:0] reg_index;
	logic active;
	logic id_active;

	assign device = bus_req_i.address.fields.device;
	assign reg_index = bus_req_i.address.fields.reg_index;
	assign active = bus_req_i.we || bus_req_i.oe;
	assign id_active = active && (device == `PERIPH_DEV_ID);

	// Unselected targets see an idle bus
	assign gpio_req_o = (device == `PERIPH_DEV_GPIO) ? bus_req_i : periph_req_idle;
	assign timer_req_o = (device == `PERIPH_DEV_TIMER) ? bus_req_i : periph_req_idle;

	always_comb begin
		bus_rsp_o.busy = 1'b0;
		bus_rsp_o.data_read = `PERIPH_UNMAPPED_DATA;
		case (device)
			`PERIPH_DEV_ID: begin
				if (reg_index == '0) begin
					bus_rsp_o.data_read = `PERIPH_SUBSYSTEM_ID;
				end
			end
			`PERIPH_DEV_GPIO: bus_rsp_o = gpio_rsp_i;
			`PERIPH_DEV_TIMER: bus_rsp_o = timer_rsp_i;
			default: begin
				bus_rsp_o.busy = 1'b0;
			end
		endcase
	end

	// One target at most is addressed at a time
	assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
		$onehot0({id_active,
			gpio_req_o.we || gpio_req_o.oe,
			timer_req_o.we || timer_req_o.oe}));

endmodule

`default_nettype wire

/* source/wb_periph_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

`include "periph_config.svh"

module wb_periph_bridge (
	input  wire                            wb_clk_i,
	input  wire                            wb_rst_i,
	input  wire                            wb_cyc_i,
	input  wire                            wb_stb_i,
	input  wire                            wb_we_i,
	input  wire [3:0]                      wb_sel_i,
	input  wire [`PERIPH_ADDR_WIDTH-1:0]   wb_adr_i,
	input  wire [`PERIPH_DATA_WIDTH-1:0]   wb_dat_i,
	output logic [`PERIPH_DATA_WIDTH-1:0]  wb_dat_o,
	output logic                           wb_ack_o,
	output logic                           wb_stall_o,
	input  wire periph_pkg::periph_rsp_t   bus_rsp_i,
	output periph_pkg::periph_req_t        bus_req_o
);
	import periph_pkg::*;

	typedef enum logic [1:0] {
		state_idle  = 2'h0,
		state_write = 2'h1,
		state_read  = 2'h2
	} state_t;

	state_t state;
	periph_addr_u addr_q;
	logic [3:0] sel_q;
	logic [`PERIPH_DATA_WIDTH-1:0] wdata_q;
	logic [`PERIPH_DATA_WIDTH-1:0] rdata_q;
	logic ack_q;
	logic accept;
	logic active;
	logic complete;

	assign accept = (state == state_idle) && wb_cyc_i && wb_stb_i;
	assign active = (state != state_idle);
	assign complete = active && !bus_rsp_i.busy;

	// ----------------------------------------------------------------------
	// Control FSM
	// ----------------------------------------------------------------------
	always_ff @(posedge wb_clk_i) begin
		if (wb_rst_i) begin
			state <= state_idle;
			ack_q <= 1'b0;
		end else begin
			ack_q <= complete;
			case (state)
				state_idle: begin
					if (accept) begin
						state <= wb_we_i ? state_write : state_read;
					end
				end
				state_write, state_read: begin
					if (!bus_rsp_i.busy) begin
						state <= state_idle;
					end
				end
				default: begin
					state <= state_idle;
				end
			endcase
		end
	end

	// Captured access and read result
	always_ff @(posedge wb_clk_i) begin
		if (accept) begin
			addr_q.raw <= wb_adr_i;
			sel_q <= wb_sel_i;
			wdata_q <= wb_dat_i;
		end
		if (complete && state == state_read) begin
			rdata_q <= bus_rsp_i.data_read;
		end
	end

	assign wb_ack_o = ack_q;
	assign wb_stall_o = active;
	assign wb_dat_o = rdata_q;

	// Fields are zero outside an active request
	always_comb begin
		bus_req_o = periph_req_idle;
		bus_req_o.we = (state == state_write);
		bus_req_o.oe = (state == state_read);
		if (active) begin
			bus_req_o.address = addr_q;
			bus_req_o.byte_select = sel_q;
		end
		if (state == state_write) begin
			bus_req_o.data_write = wdata_q;
		end
	end

	// Ack is a single-cycle pulse
	assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
		wb_ack_o |=> !wb_ack_o);

	// Target back-pressure freezes the request
	assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
		(active && bus_rsp_i.busy) |=> $stable(bus_req_o));

endmodule

`default_nettype wire

/* source/periph_pkg.sv */
`default_nettype none

`include "periph_config.svh"

package periph_pkg;

	// ----------------------------------------------------------------------
	// Address views
	// ----------------------------------------------------------------------
	typedef struct packed {
		logic [`PERIPH_ADDR_WIDTH-`PERIPH_DEV_LSB-`PERIPH_DEV_BITS-1:0] unused;
		logic [`PERIPH_DEV_BITS-1:0]                                    device;
		logic [`PERIPH_DEV_LSB-`PERIPH_REG_LSB-`PERIPH_REG_BITS-1:0]   filler;
		logic [`PERIPH_REG_BITS-1:0]                                    reg_index;
		logic [`PERIPH_REG_LSB-1:0]                                     byte_offset;
	} periph_addr_t;

	typedef union packed {
		logic [`PERIPH_ADDR_WIDTH-1:0] raw;
		periph_addr_t                  fields;
	} periph_addr_u;

	// ----------------------------------------------------------------------
	// Peripheral bus
	// ----------------------------------------------------------------------
	typedef struct packed {
		logic                          we;
		logic                          oe;
		periph_addr_u                  address;
		logic [3:0]                    byte_select;
		logic [`PERIPH_DATA_WIDTH-1:0] data_write;
	} periph_req_t;

	typedef struct packed {
		logic                          busy;
		logic [`PERIPH_DATA_WIDTH-1:0] data_read;
	} periph_rsp_t;

	localparam periph_req_t periph_req_idle = '0;

	// Write only the lanes flagged in byte_select
	function automatic logic [`PERIPH_DATA_WIDTH-1:0] byte_merge(
		input logic [`PERIPH_DATA_WIDTH-1:0] old_word,
		input logic [`PERIPH_DATA_WIDTH-1:0] new_word,
		input logic [3:0]                    byte_select
	);
		logic [`PERIPH_DATA_WIDTH-1:0] merged;
		merged = old_word;
		for (int i = 0; i < 4; i++) begin
			if (byte_select[i]) begin
				merged[8*i +: 8] = new_word[8*i +: 8];
			end
		end
		return merged;
	endfunction

endpackage

`default_nettype wire

/* source/periph_config.svh */
`ifndef PERIPH_CONFIG_SVH
`define PERIPH_CONFIG_SVH

// Bus widths
`define PERIPH_ADDR_WIDTH 24
`define PERIPH_DATA_WIDTH 32

// Address field positions
`define PERIPH_DEV_LSB  16
`define PERIPH_DEV_BITS 4
`define PERIPH_REG_LSB  2
`define PERIPH_REG_BITS 4

// Device map
`define PERIPH_DEV_ID    4'h0
`define PERIPH_DEV_GPIO  4'h1
`define PERIPH_DEV_TIMER 4'h2

`define PERIPH_SUBSYSTEM_ID  32'h5045_5249
`define PERIPH_UNMAPPED_DATA 32'hbad0_bad0

`define GPIO_WIDTH 32

`endif
